/* source/pfp_pkg.sv */
`default_nettype none

package pfp_pkg;

    localparam int PC_W       = 30;
    localparam int ADDR_W     = 27;
    localparam int HASH_W     = 10;
    localparam int N_BANKS    = 4;
    localparam int BANK_SEL_W = 2;
    localparam int IDX_W      = 8;
    localparam int CONF_W     = 2;
    localparam int N_ENTRIES  = 1 << IDX_W;

    localparam logic [CONF_W-1:0] CONF_INIT = 2'd2;
    localparam logic [CONF_W-1:0] CONF_MAX  = '1;

    // slices of HASH_W bits needed to cover a pc
    localparam int N_SLICE = (PC_W + HASH_W - 1) / HASH_W;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
    } lookup_t;

    typedef struct packed {
        logic              valid;
        logic [PC_W-1:0]   pc;
        logic [ADDR_W-1:0] addr;
    } train_t;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        logic            useful;
    } fb_t;

    // per-bank request after hashing
    typedef struct packed {
        logic              lk_valid;
        logic [IDX_W-1:0]  lk_idx;
        logic              tr_valid;
        logic [IDX_W-1:0]  tr_idx;
        logic [PC_W-1:0]   tr_pc;
        logic [ADDR_W-1:0] tr_addr;
        logic              fb_valid;
        logic [IDX_W-1:0]  fb_idx;
        logic [PC_W-1:0]   fb_pc;
        logic              fb_useful;
    } bank_req_t;

    typedef struct packed {
        logic              valid;
        logic [PC_W-1:0]   tag;
        logic [ADDR_W-1:0] naddr;
        logic [CONF_W-1:0] conf;
    } bank_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } pf_req_t;

    // xor fold of the pc, upper slice zero padded
    function automatic logic [HASH_W-1:0] pc_hash(input logic [PC_W-1:0] pc);
        logic [N_SLICE*HASH_W-1:0] padded;
        logic [HASH_W-1:0]         h;
        padded          = '0;
        padded[PC_W-1:0] = pc;
        h               = '0;
        for (int i = 0; i < N_SLICE; i++) begin
            h = h ^ padded[i*HASH_W +: HASH_W];
        end
        return h;
    endfunction

endpackage

`default_nettype wire

/* source/pfp_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module pfp_dispatch
    import pfp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire lookup_t               lookup,
    input  wire train_t                train,
    input  wire fb_t                   feedback,
    output bank_req_t                  bank_req [N_BANKS],
    output logic      [BANK_SEL_W-1:0] lookup_bank,
    output logic      [PC_W-1:0]       lookup_pc
);

    logic [HASH_W-1:0] lk_hash;
    logic [HASH_W-1:0] tr_hash;
    logic [HASH_W-1:0] fb_hash;

    assign lk_hash = pc_hash(lookup.pc);
    assign tr_hash = pc_hash(train.pc);
    assign fb_hash = pc_hash(feedback.pc);

    // low hash bits pick the bank, the rest index into it
    always_comb begin
        for (int b = 0; b < N_BANKS; b++) begin
            bank_req[b].lk_valid  = lookup.valid
                                    && (lk_hash[BANK_SEL_W-1:0] == BANK_SEL_W'(b));
            bank_req[b].lk_idx    = lk_hash[HASH_W-1:BANK_SEL_W];
            bank_req[b].tr_valid  = train.valid
                                    && (tr_hash[BANK_SEL_W-1:0] == BANK_SEL_W'(b));
            bank_req[b].tr_idx    = tr_hash[HASH_W-1:BANK_SEL_W];
            bank_req[b].tr_pc     = train.pc;
            bank_req[b].tr_addr   = train.addr;
            bank_req[b].fb_valid  = feedback.valid
                                    && (fb_hash[BANK_SEL_W-1:0] == BANK_SEL_W'(b));
            bank_req[b].fb_idx    = fb_hash[HASH_W-1:BANK_SEL_W];
            bank_req[b].fb_pc     = feedback.pc;
            bank_req[b].fb_useful = feedback.useful;
        end
    end

    // lines up with the registered bank read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_bank <= '0;
            lookup_pc   <= '0;
        end else begin
            lookup_bank <= lk_hash[BANK_SEL_W-1:0];
            lookup_pc   <= lookup.pc;
        end
    end

endmodule

`default_nettype wire

/* source/pfp_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module pfp_bank
    import pfp_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire bank_req_t req,
    output bank_rsp_t      rsp
);

    // entry storage
    logic [N_ENTRIES-1:0] valid_q;
    logic [PC_W-1:0]      tag_mem  [N_ENTRIES];
    logic [ADDR_W-1:0]    addr_mem [N_ENTRIES];
    logic [CONF_W-1:0]    conf_mem [N_ENTRIES];

    // registered lookup result
    logic              rsp_valid_q;
    logic [PC_W-1:0]   rsp_tag_q;
    logic [ADDR_W-1:0] rsp_addr_q;
    logic [CONF_W-1:0] rsp_conf_q;

    // feedback pipeline
    logic              fb_hit;
    logic [CONF_W-1:0] fb_cur_conf;
    logic [CONF_W-1:0] fb_next_conf;
    logic              pend_valid_q;
    logic [IDX_W-1:0]  pend_idx_q;
    logic [CONF_W-1:0] pend_conf_q;

    // a training in the same cycle wins over the feedback
    assign fb_hit = req.fb_valid && !req.tr_valid && valid_q[req.fb_idx]
                    && (tag_mem[req.fb_idx] == req.fb_pc);

    // forward a counter update that has not been written yet
    assign fb_cur_conf = (pend_valid_q && (pend_idx_q == req.fb_idx))
                         ? pend_conf_q : conf_mem[req.fb_idx];

    always_comb begin
        fb_next_conf = fb_cur_conf;
        if (req.fb_useful) begin
            if (fb_cur_conf != CONF_MAX) begin
                fb_next_conf = fb_cur_conf + 1'b1;
            end
        end else if (fb_cur_conf != '0) begin
            fb_next_conf = fb_cur_conf - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= '0;
            pend_valid_q <= 1'b0;
            rsp_valid_q  <= 1'b0;
        end else begin
            if (req.tr_valid) begin
                valid_q[req.tr_idx] <= 1'b1;
            end
            pend_valid_q <= fb_hit;
            // only meaningful in the cycle after a lookup
            rsp_valid_q  <= req.lk_valid && valid_q[req.lk_idx];
        end
    end

    always_ff @(posedge clk) begin
        pend_idx_q  <= req.fb_idx;
        pend_conf_q <= fb_next_conf;
    end

    // read first, so a lookup sees the content before this edge's write
    always_ff @(posedge clk) begin
        rsp_tag_q  <= tag_mem[req.lk_idx];
        rsp_addr_q <= addr_mem[req.lk_idx];
        rsp_conf_q <= conf_mem[req.lk_idx];
    end

    // single write port, training first
    always_ff @(posedge clk) begin
        if (req.tr_valid) begin
            tag_mem[req.tr_idx]  <= req.tr_pc;
            addr_mem[req.tr_idx] <= req.tr_addr;
            conf_mem[req.tr_idx] <= CONF_INIT;
        end else if (pend_valid_q) begin
            conf_mem[pend_idx_q] <= pend_conf_q;
        end
    end

    assign rsp = '{
        valid: rsp_valid_q,
        tag:   rsp_tag_q,
        naddr: rsp_addr_q,
        conf:  rsp_conf_q
    };

endmodule

`default_nettype wire

/* source/pfp_select.sv */
`timescale 1ns/100ps
`default_nettype none

module pfp_select
    import pfp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire bank_rsp_t             rsp [N_BANKS],
    input  wire logic [BANK_SEL_W-1:0] lookup_bank,
    input  wire logic [PC_W-1:0]       lookup_pc,
    output pf_req_t                    pf_req
);

    bank_rsp_t sel_rsp;
    logic      tag_match;
    logic      confident;
    logic      issue;

    // only the bank the lookup went to holds a live result
    assign sel_rsp = rsp[lookup_bank];

    // full pc is stored, so the tag check removes hash aliases
    assign tag_match = (sel_rsp.tag == lookup_pc);

    // upper counter bit means weak or strong confident
    assign confident = sel_rsp.conf[CONF_W-1];

    assign issue = sel_rsp.valid && tag_match && confident;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pf_req <= '0;
        end else begin
            pf_req.valid <= issue;
            // address kept at zero when there is no request
            if (issue) begin
                pf_req.addr <= sel_rsp.naddr;
            end else begin
                pf_req.addr <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/data_prefetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module data_prefetch_top
    import pfp_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire lookup_t lookup,
    input  wire train_t  train,
    input  wire fb_t     feedback,
    output pf_req_t      pf_req
);

    bank_req_t             bank_req [N_BANKS];
    bank_rsp_t             bank_rsp [N_BANKS];
    logic [BANK_SEL_W-1:0] lookup_bank;
    logic [PC_W-1:0]       lookup_pc;

    pfp_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup      (lookup),
        .train       (train),
        .feedback    (feedback),
        .bank_req    (bank_req),
        .lookup_bank (lookup_bank),
        .lookup_pc   (lookup_pc)
    );

    // one table slice per bank
    for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
        pfp_bank u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (bank_req[g]),
            .rsp   (bank_rsp[g])
        );
    end

    pfp_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp         (bank_rsp),
        .lookup_bank (lookup_bank),
        .lookup_pc   (lookup_pc),
        .pf_req      (pf_req)
    );

endmodule

`default_nettype wire

/* verif/pfp_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module pfp_properties
    import pfp_pkg::*;
(
    input wire logic    clk,
    input wire logic    rst_n,
    input wire lookup_t lookup,
    input wire pf_req_t pf_req
);

    int assert_failures;

    initial assert_failures = 0;

    // output register is cleared asynchronously
    no_req_in_reset: assert property (@(posedge clk) !rst_n |-> !pf_req.valid)
        else begin
            assert_failures++;
            $error("prefetch request valid while in reset");
        end

    addr_zero_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) !pf_req.valid |-> (pf_req.addr == '0))
        else begin
            assert_failures++;
            $error("prefetch address not zero without a request");
        end

    // bank read and output register sit between a lookup and its request
    req_follows_lookup: assert property (
        @(posedge clk) disable iff (!rst_n) pf_req.valid |-> $past(lookup.valid, 2))
        else begin
            assert_failures++;
            $error("prefetch request without a lookup two cycles earlier");
        end

endmodule

bind data_prefetch_top pfp_properties u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .lookup (lookup),
    .pf_req (pf_req)
);

`default_nettype wire

/* verif/pfp_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module pfp_checker
    import pfp_pkg::*;
(
    input  wire logic    clk,
    input  wire pf_req_t pf_req,
    input  wire logic    exp_push,
    input  wire pf_req_t exp_req,
    output int           pending,
    output int           mismatches
);

    typedef struct packed {
        pf_req_t     req;
        logic [31:0] stamp;
    } exp_entry_t;

    exp_entry_t  exp_q [$];
    exp_entry_t  head;
    logic [31:0] cycle;

    initial begin
        cycle      = '0;
        pending    = 0;
        mismatches = 0;
    end

    // capture on the rising edge, compare on the falling edge
    always @(posedge clk or negedge clk) begin
        if (clk) begin
            cycle = cycle + 1;
            if (exp_push) begin
                exp_q.push_back('{req: exp_req, stamp: cycle});
            end
        end else if (exp_q.size() != 0 && cycle == exp_q[0].stamp + 1) begin
            // the request for a lookup is registered one edge after the lookup was sampled
            head = exp_q.pop_front();
            if (pf_req.valid !== head.req.valid) begin
                $display("error at %0t: pf_req.valid is %0b, expected %0b",
                         $time, pf_req.valid, head.req.valid);
                mismatches++;
            end
            if (pf_req.addr !== head.req.addr) begin
                $display("error at %0t: pf_req.addr is %h, expected %h",
                         $time, pf_req.addr, head.req.addr);
                mismatches++;
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* verif/tb_data_prefetch.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_data_prefetch
    import pfp_pkg::*;
();

    logic    clk;
    logic    rst_n;
    lookup_t lookup;
    train_t  train;
    fb_t     feedback;
    pf_req_t pf_req;
    pf_req_t exp_req;
    logic    exp_push;
    int      pending;
    int      mismatches;
    int      other_errors;

    data_prefetch_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .lookup   (lookup),
        .train    (train),
        .feedback (feedback),
        .pf_req   (pf_req)
    );

    pfp_checker u_check (
        .clk        (clk),
        .pf_req     (pf_req),
        .exp_push   (exp_push),
        .exp_req    (exp_req),
        .pending    (pending),
        .mismatches (mismatches)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int                fd;
        int                n_fields;
        int                n_lines;
        int                wait_cycles;
        string             line;
        logic              lk_v, tr_v, fb_v, fb_use, ex_v;
        logic [PC_W-1:0]   lk_pc, tr_pc, fb_pc;
        logic [ADDR_W-1:0] tr_addr, ex_addr;

        rst_n        = 1'b0;
        lookup       = '0;
        train        = '0;
        feedback     = '0;
        exp_req      = '0;
        exp_push     = 1'b0;
        other_errors = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("verif/pfp_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/pfp_testdata.txt");
            other_errors++;
        end else begin
            n_lines = 0;
            // one data line per cycle, comment lines take no time
            while (!$feof(fd) && n_lines < 1000) begin
                n_lines++;
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                       lk_v, lk_pc, tr_v, tr_pc, tr_addr,
                                       fb_v, fb_pc, fb_use, ex_v, ex_addr);
                    if (n_fields != 10) begin
                        $display("malformed test data line: %s", line);
                        other_errors++;
                    end else begin
                        lookup   = '{valid: lk_v, pc: lk_pc};
                        train    = '{valid: tr_v, pc: tr_pc, addr: tr_addr};
                        feedback = '{valid: fb_v, pc: fb_pc, useful: fb_use};
                        exp_req  = '{valid: ex_v, addr: ex_addr};
                        exp_push = 1'b1;
                        @(negedge clk);
                    end
                end
            end
            $fclose(fd);
        end
        lookup   = '0;
        train    = '0;
        feedback = '0;
        exp_push = 1'b0;

        wait_cycles = 0;
        while (pending != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected requests were never compared", pending);
            other_errors++;
        end

        $display("errors: %0d mismatches, %0d assertion failures, %0d other",
                 mismatches, dut0.u_props.assert_failures, other_errors);
        if (mismatches == 0 && other_errors == 0
            && dut0.u_props.assert_failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/pfp_pkg.sv
source/pfp_dispatch.sv
source/pfp_bank.sv
source/pfp_select.sv
source/data_prefetch_top.sv
verif/pfp_properties.sv
verif/pfp_checker.sv
verif/tb_data_prefetch.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_data_prefetch -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

/* verif/pfp_testdata.txt */
# lk_valid lk_pc tr_valid tr_pc tr_addr fb_valid fb_pc fb_useful exp_valid exp_addr
# all hex, one line per cycle, expected request belongs to this line's lookup
1 010 0 000 0000000 0 000 0 0 0000000
1 025 0 000 0000000 0 000 0 0 0000000
1 010 1 010 1234567 0 000 0 0 0000000
1 010 0 000 0000000 0 000 0 1 1234567
0 000 1 025 0abcdef 0 000 0 0 0000000
1 025 0 000 0000000 0 000 0 1 0abcdef
0 000 1 03a 2222222 0 000 0 0 0000000
1 03a 1 04f 3333333 0 000 0 1 2222222
1 04f 0 000 0000000 0 000 0 1 3333333
1 010 0 000 0000000 0 000 0 1 1234567
1 025 0 000 0000000 0 000 0 1 0abcdef
0 000 0 000 0000000 1 025 0 0 0000000
0 000 0 000 0000000 1 025 0 0 0000000
1 010 0 000 0000000 0 000 0 1 1234567
1 025 0 000 0000000 0 000 0 0 0000000
0 000 0 000 0000000 1 025 1 0 0000000
0 000 0 000 0000000 1 025 1 0 0000000
0 000 0 000 0000000 1 025 1 0 0000000
0 000 0 000 0000000 1 025 1 0 0000000
1 04f 0 000 0000000 0 000 0 1 3333333
1 025 0 000 0000000 0 000 0 1 0abcdef
0 000 1 411 5555555 0 000 0 0 0000000
1 010 0 000 0000000 0 000 0 0 0000000
1 411 0 000 0000000 0 000 0 1 5555555
0 000 1 060 6060606 0 000 0 0 0000000
0 000 1 064 7070707 1 060 0 0 0000000
1 064 0 000 0000000 0 000 0 1 7070707
1 060 0 000 0000000 0 000 0 1 6060606
